//--- hdl/read_store_pkg.sv
`default_nettype none

package read_store_pkg;

	// one load beat and one compressed read
	typedef logic [511:0] line_t;
	typedef logic [255:0] code_line_t;

	typedef logic [1:0] base_code_t;
	typedef logic [7:0] base_byte_t;

	typedef logic [5:0] read_num_t;
	// one bit wider than read_num_t so a full batch of 64 fits
	typedef logic [6:0] batch_t;
	typedef logic [6:0] base_pos_t;

	typedef logic [63:0] ik_t;
	typedef logic [6:0] intv_t;

	localparam int BASES_PER_BEAT = 64;

	// order in which the beats of one read arrive
	typedef enum logic [1:0] {
		read_lo,
		read_hi,
		param,
		ik
	} load_beat_e;

endpackage

`default_nettype wire

//--- hdl/read_loader.sv
`default_nettype none

module read_loader #(
	parameter int MAX_READS = 64
) (
	input  logic                                    clk,
	input  logic                                    reset_n,
	input  logic                                    load_valid,
	input  read_store_pkg::line_t                   load_data,
	input  read_store_pkg::batch_t                  batch_size,
	output logic                                    base_we,
	output logic                                    base_half,
	output logic [2*read_store_pkg::BASES_PER_BEAT-1:0] base_codes,
	output logic                                    param_we,
	output logic                                    ik_we,
	output read_store_pkg::read_num_t               wr_read_num,
	output read_store_pkg::batch_t                  loaded_count,
	output logic                                    load_done
);

	read_store_pkg::load_beat_e beat;
	logic accept;

	// beats past the memory depth are dropped
	assign accept = load_valid && (loaded_count < read_store_pkg::batch_t'(MAX_READS));

	assign base_we     = accept && (beat == read_store_pkg::read_lo ||
		beat == read_store_pkg::read_hi);
	assign base_half   = (beat == read_store_pkg::read_hi);
	assign param_we    = accept && (beat == read_store_pkg::param);
	assign ik_we       = accept && (beat == read_store_pkg::ik);
	assign wr_read_num = loaded_count[5:0];

	// low two bits of every byte are the base code
	always_comb begin
		for (int k = 0; k < read_store_pkg::BASES_PER_BEAT; k++) begin
			base_codes[2*k +: 2] = load_data[8*k +: 2];
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			beat         <= read_store_pkg::read_lo;
			loaded_count <= '0;
			load_done    <= 1'b0;
		end else begin
			if (accept) begin
				unique case (beat)
					read_store_pkg::read_lo: beat <= read_store_pkg::read_hi;
					read_store_pkg::read_hi: beat <= read_store_pkg::param;
					read_store_pkg::param:   beat <= read_store_pkg::ik;
					read_store_pkg::ik: begin
						beat         <= read_store_pkg::read_lo;
						loaded_count <= loaded_count + 1'b1;
					end
				endcase
			end
			// sticky until the next reset
			if (loaded_count == batch_size && batch_size != '0) begin
				load_done <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/base_ram.sv
`default_nettype none

module base_ram #(
	parameter int MAX_READS = 64
) (
	input  logic                                        clk,
	input  logic                                        we,
	input  logic                                        half,
	input  read_store_pkg::read_num_t                   wr_read_num,
	input  logic [2*read_store_pkg::BASES_PER_BEAT-1:0] wr_codes,
	input  read_store_pkg::read_num_t                   rd_read_num,
	output read_store_pkg::code_line_t                  rd_line
);

	localparam int AW = (MAX_READS > 1) ? $clog2(MAX_READS) : 1;

	// bases 0..63 in lo_mem, 64..127 in hi_mem
	logic [2*read_store_pkg::BASES_PER_BEAT-1:0] lo_mem [MAX_READS];
	logic [2*read_store_pkg::BASES_PER_BEAT-1:0] hi_mem [MAX_READS];

	logic [AW-1:0] wr_addr;
	logic [AW-1:0] rd_addr;

	assign wr_addr = wr_read_num[AW-1:0];
	assign rd_addr = rd_read_num[AW-1:0];

	always_ff @(posedge clk) begin
		if (we && !half) begin
			lo_mem[wr_addr] <= wr_codes;
		end
		if (we && half) begin
			hi_mem[wr_addr] <= wr_codes;
		end
	end

	assign rd_line = {hi_mem[rd_addr], lo_mem[rd_addr]};

endmodule

`default_nettype wire

//--- hdl/seed_param_ram.sv
`default_nettype none

module seed_param_ram #(
	parameter int MAX_READS = 64
) (
	input  logic                      clk,
	input  logic                      param_we,
	input  logic                      ik_we,
	input  read_store_pkg::read_num_t wr_read_num,
	input  read_store_pkg::line_t     wr_data,
	input  read_store_pkg::read_num_t rd_read_num,
	output read_store_pkg::intv_t     forward_i,
	output read_store_pkg::intv_t     min_intv,
	output read_store_pkg::ik_t       ik_x0,
	output read_store_pkg::ik_t       ik_x1,
	output read_store_pkg::ik_t       ik_x2,
	output read_store_pkg::ik_t       ik_info
);

	localparam int AW = (MAX_READS > 1) ? $clog2(MAX_READS) : 1;

	read_store_pkg::intv_t fwd_mem [MAX_READS];
	read_store_pkg::intv_t min_mem [MAX_READS];
	logic [32:0]           x0_mem  [MAX_READS];
	logic [32:0]           x1_mem  [MAX_READS];
	logic [32:0]           x2_mem  [MAX_READS];
	// upper seven info bits in 13..7, lower seven in 6..0
	logic [13:0]           info_mem [MAX_READS];

	logic [AW-1:0] wr_addr;
	logic [AW-1:0] rd_addr;

	assign wr_addr = wr_read_num[AW-1:0];
	assign rd_addr = rd_read_num[AW-1:0];

	always_ff @(posedge clk) begin
		if (param_we) begin
			fwd_mem[wr_addr] <= wr_data[6:0];
			min_mem[wr_addr] <= wr_data[70:64];
		end
		if (ik_we) begin
			x0_mem[wr_addr]   <= wr_data[32:0];
			x1_mem[wr_addr]   <= wr_data[96:64];
			x2_mem[wr_addr]   <= wr_data[160:128];
			info_mem[wr_addr] <= {wr_data[230:224], wr_data[198:192]};
		end
	end

	assign forward_i = fwd_mem[rd_addr];
	assign min_intv  = min_mem[rd_addr];
	assign ik_x0     = {31'b0, x0_mem[rd_addr]};
	assign ik_x1     = {31'b0, x1_mem[rd_addr]};
	assign ik_x2     = {31'b0, x2_mem[rd_addr]};
	assign ik_info   = {25'b0, info_mem[rd_addr][13:7], 25'b0, info_mem[rd_addr][6:0]};

endmodule

`default_nettype wire

//--- hdl/read_dispatcher.sv
`default_nettype none

module read_dispatcher (
	input  logic                      clk,
	input  logic                      reset_n,
	input  logic                      load_done,
	input  read_store_pkg::batch_t    loaded_count,
	input  logic                      read_ready,
	output logic                      read_valid,
	output read_store_pkg::read_num_t read_num
);

	// next read to hand out, one bit wider so it can reach a full batch
	read_store_pkg::batch_t read_ptr;
	logic                   xfer;

	assign read_valid = load_done && (read_ptr < loaded_count);
	assign read_num   = read_ptr[5:0];
	assign xfer       = read_valid && read_ready;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			read_ptr <= '0;
		end else if (xfer) begin
			read_ptr <= read_ptr + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hdl/base_query_pipe.sv
`default_nettype none

module base_query_pipe (
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic                       query_valid,
	input  read_store_pkg::read_num_t  query_read_num,
	input  read_store_pkg::base_pos_t  query_pos,
	input  read_store_pkg::code_line_t rd_line,
	input  logic                       result_ready,
	output logic                       query_ready,
	output read_store_pkg::read_num_t  rd_read_num,
	output logic                       result_valid,
	output read_store_pkg::base_byte_t result_base
);

	logic advance;

	logic                       s0_valid;
	read_store_pkg::code_line_t s0_line;
	read_store_pkg::base_pos_t  s0_pos;

	// 32 codes left after stage 1
	logic        s1_valid;
	logic [63:0] s1_sel;
	logic [4:0]  s1_pos;

	// 8 codes left after stage 2
	logic        s2_valid;
	logic [15:0] s2_sel;
	logic [2:0]  s2_pos;

	logic                       s3_valid;
	read_store_pkg::base_code_t s3_code;

	// every stage moves only when the output can take a result
	assign advance     = !result_valid || result_ready;
	assign query_ready = advance;
	assign rd_read_num = query_read_num;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			s0_valid <= 1'b0;
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
		end else if (advance) begin
			s0_valid <= query_valid;
			s1_valid <= s0_valid;
			s2_valid <= s1_valid;
			s3_valid <= s2_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			s0_line <= rd_line;
			s0_pos  <= query_pos;
			// position bits 6..5 choose a quarter, 0 and 1 sit in the low half
			s1_sel  <= s0_line[s0_pos[6:5]*64 +: 64];
			s1_pos  <= s0_pos[4:0];
			s2_sel  <= s1_sel[s1_pos[4:3]*16 +: 16];
			s2_pos  <= s1_pos[2:0];
			s3_code <= s2_sel[s2_pos*2 +: 2];
		end
	end

	assign result_valid = s3_valid;
	assign result_base  = {6'b0, s3_code};

endmodule

`default_nettype wire

//--- hdl/read_store_top.sv
`default_nettype none

module read_store_top #(
	parameter int MAX_READS = 64
) (
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic                       load_valid,
	input  read_store_pkg::line_t      load_data,
	input  read_store_pkg::batch_t     batch_size,
	output logic                       load_done,
	output logic                       read_valid,
	input  logic                       read_ready,
	output read_store_pkg::read_num_t  read_num,
	output read_store_pkg::intv_t      forward_i,
	output read_store_pkg::intv_t      min_intv,
	output read_store_pkg::ik_t        ik_x0,
	output read_store_pkg::ik_t        ik_x1,
	output read_store_pkg::ik_t        ik_x2,
	output read_store_pkg::ik_t        ik_info,
	input  logic                       query_valid,
	output logic                       query_ready,
	input  read_store_pkg::read_num_t  query_read_num,
	input  read_store_pkg::base_pos_t  query_pos,
	output logic                       result_valid,
	input  logic                       result_ready,
	output read_store_pkg::base_byte_t result_base
);

	logic                                        base_we;
	logic                                        base_half;
	logic [2*read_store_pkg::BASES_PER_BEAT-1:0] base_codes;
	logic                                        param_we;
	logic                                        ik_we;
	read_store_pkg::read_num_t                   wr_read_num;
	read_store_pkg::batch_t                      loaded_count;
	read_store_pkg::read_num_t                   query_rd_num;
	read_store_pkg::code_line_t                  query_line;

	read_loader #(.MAX_READS(MAX_READS)) loader0 (
		.clk, .reset_n, .load_valid, .load_data, .batch_size,
		.base_we, .base_half, .base_codes, .param_we, .ik_we,
		.wr_read_num, .loaded_count, .load_done
	);

	base_ram #(.MAX_READS(MAX_READS)) bases0 (
		.clk, .we(base_we), .half(base_half), .wr_read_num,
		.wr_codes(base_codes), .rd_read_num(query_rd_num), .rd_line(query_line)
	);

	// dispatch reads this memory at the dispatch pointer
	seed_param_ram #(.MAX_READS(MAX_READS)) params0 (
		.clk, .param_we, .ik_we, .wr_read_num, .wr_data(load_data),
		.rd_read_num(read_num), .forward_i, .min_intv,
		.ik_x0, .ik_x1, .ik_x2, .ik_info
	);

	read_dispatcher dispatch0 (
		.clk, .reset_n, .load_done, .loaded_count, .read_ready,
		.read_valid, .read_num
	);

	base_query_pipe query0 (
		.clk, .reset_n, .query_valid, .query_read_num, .query_pos,
		.rd_line(query_line), .result_ready, .query_ready,
		.rd_read_num(query_rd_num), .result_valid, .result_base
	);

endmodule

`default_nettype wire

//--- test/read_store_props.sv
`default_nettype none

module read_store_props (
	input logic                       clk,
	input logic                       reset_n,
	input logic                       load_done,
	input logic                       read_valid,
	input logic                       result_valid,
	input logic                       result_ready,
	input read_store_pkg::base_byte_t result_base
);

	timeunit 1ns;
	timeprecision 1ps;

	// a stalled result holds until it is taken
	result_held: assert property (@(posedge clk) disable iff (!reset_n)
		result_valid && !result_ready |=> result_valid && $stable(result_base))
		else $error("result changed while the output was stalled");

	dispatch_after_load: assert property (@(posedge clk) read_valid |-> load_done)
		else $error("read_valid high before the batch was loaded");

	// first reset edge clears the registers, checked from the second on
	quiet_in_reset: assert property (@(posedge clk)
		!reset_n ##1 !reset_n |-> !load_done && !read_valid && !result_valid)
		else $error("a valid output was high during reset");

endmodule

`default_nettype wire

//--- test/read_store_tb.sv
`default_nettype none

module read_store_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NREADS = 6;

	logic clk = 1'b0;
	logic reset_n, load_valid, read_ready, query_valid, result_ready;
	logic load_done, read_valid, query_ready, result_valid;
	read_store_pkg::line_t      load_data;
	read_store_pkg::batch_t     batch_size;
	read_store_pkg::read_num_t  read_num, query_read_num;
	read_store_pkg::base_pos_t  query_pos;
	read_store_pkg::intv_t      forward_i, min_intv;
	read_store_pkg::ik_t        ik_x0, ik_x1, ik_x2, ik_info;
	read_store_pkg::base_byte_t result_base;

	// beats of each read in arrival order: lo, hi, param, ik
	read_store_pkg::line_t beats [NREADS][4];
	read_store_pkg::base_byte_t exp_q [$];
	int acc_q [$];
	int errors = 0, checks = 0, cyc = 0, disp_idx = 0, results = 0, issued = 0;
	int accepted = 0, max_inflight = 0, test_no = 0, test_err0 = 0;
	logic stall_mode = 1'b0;
	string names [7] = '{"read_num", "forward_i", "min_intv", "ik_x0", "ik_x1", "ik_x2", "ik_info"};

	read_store_top #(.MAX_READS(64)) dut0 (.*);

	bind read_store_top read_store_props props0 (
		.clk, .reset_n, .load_done, .read_valid, .result_valid, .result_ready, .result_base
	);

	always #2 clk = ~clk;

	always @(negedge clk) begin
		result_ready = stall_mode ? 1'($urandom) : 1'b1;
	end

	function automatic read_store_pkg::line_t rand_line();
		read_store_pkg::line_t l;
		for (int w = 0; w < 16; w++) begin
			l[32*w +: 32] = $urandom;
		end
		return l;
	endfunction

	// dispatch field f of read r, straight from the beat layouts
	function automatic logic [63:0] ref_field(int r, int f);
		read_store_pkg::line_t pb;
		read_store_pkg::line_t kb;
		pb = beats[r][2];
		kb = beats[r][3];
		case (f)
			0: return 64'(r);
			1: return {57'b0, pb[6:0]};
			2: return {57'b0, pb[70:64]};
			3: return {31'b0, kb[32:0]};
			4: return {31'b0, kb[96:64]};
			5: return {31'b0, kb[160:128]};
			default: return {25'b0, kb[230:224], 25'b0, kb[198:192]};
		endcase
	endfunction

	function automatic logic [63:0] got_field(int f);
		case (f)
			0: return 64'(read_num);
			1: return 64'(forward_i);
			2: return 64'(min_intv);
			3: return ik_x0;
			4: return ik_x1;
			5: return ik_x2;
			default: return ik_info;
		endcase
	endfunction

	// base p sits in byte p%64 of the lo or hi beat
	function automatic read_store_pkg::base_byte_t ref_base(int r, int p);
		read_store_pkg::line_t b;
		b = beats[r][p / 64];
		return {6'b0, b[8*(p % 64) +: 2]};
	endfunction

	task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(string what, logic ok);
		checks++;
		assert (ok) else begin
			$display("%s", what);
			errors++;
		end
	endtask

	task automatic give_up(string what);
		$display("timeout while %s", what);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic end_test(string name);
		test_no++;
		$display("test %0d %s: %s", test_no, name, (errors == test_err0) ? "ok" : "errors");
		test_err0 = errors;
	endtask

	// called at a falling edge, returns at the falling edge after acceptance
	task automatic send_query(int r, int p);
		int start;
		int n;
		start = accepted;
		n = 0;
		query_valid = 1'b1;
		query_read_num = 6'(r);
		query_pos = 7'(p);
		while (accepted == start) begin
			@(negedge clk);
			n++;
			if (n > 200) give_up("waiting for query_ready");
		end
		issued++;
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
			n++;
			if (n > 1000) give_up("waiting for query results");
		end
	endtask

	always @(posedge clk) begin
		read_store_pkg::base_byte_t exp;
		int lat;
		cyc++;
		if (reset_n) begin
			if (read_valid && read_ready) begin
				check_true("dispatch went past the last loaded read", disp_idx < NREADS);
				if (disp_idx < NREADS) begin
					for (int f = 0; f < 7; f++) begin
						check_val(names[f], got_field(f), ref_field(disp_idx, f));
					end
				end
				disp_idx++;
			end
			if (result_valid && result_ready) begin
				check_true("a result came out with no query outstanding", exp_q.size() != 0);
				if (exp_q.size() != 0) begin
					exp = exp_q.pop_front();
					lat = cyc - acc_q.pop_front();
					check_val("result_base", 64'(result_base), 64'(exp));
					if (!stall_mode) begin
						check_val("result latency", 64'(lat), 64'd4);
					end
				end
				results++;
			end
			if (result_valid && !result_ready) begin
				check_val("query_ready", 64'(query_ready), 64'd0);
			end
			if (query_valid && query_ready) begin
				exp_q.push_back(ref_base(query_read_num, query_pos));
				acc_q.push_back(cyc);
				accepted++;
				if (exp_q.size() > max_inflight) max_inflight = exp_q.size();
			end
		end
	end

	initial begin
		int n;
		void'($urandom(32'ha3a3));
		reset_n = 1'b0;
		load_valid = 1'b0;
		load_data = '0;
		batch_size = 7'(NREADS);
		read_ready = 1'b0;
		query_valid = 1'b0;
		query_read_num = '0;
		query_pos = '0;
		result_ready = 1'b1;
		repeat (16) @(negedge clk);
		reset_n = 1'b1;

		check_val("load_done", 64'(load_done), 64'd0);
		check_val("read_valid", 64'(read_valid), 64'd0);
		check_val("result_valid", 64'(result_valid), 64'd0);
		for (int r = 0; r < NREADS; r++) begin
			for (int b = 0; b < 4; b++) begin
				beats[r][b] = rand_line();
				load_valid = 1'b1;
				load_data = beats[r][b];
				@(negedge clk);
				check_val("read_valid", 64'(read_valid), 64'd0);
			end
		end
		load_valid = 1'b0;
		n = 0;
		while (!load_done) begin
			@(negedge clk);
			n++;
			if (n > 50) give_up("waiting for load_done");
		end
		check_val("read_valid", 64'(read_valid), 64'd1);
		end_test("reset and load");

		n = 0;
		while (disp_idx < NREADS) begin
			read_ready = 1'($urandom);
			@(negedge clk);
			n++;
			if (n > 500) give_up("dispatching the batch");
		end
		// keep ready high one more cycle so a read past the batch would be taken
		read_ready = 1'b1;
		@(negedge clk);
		read_ready = 1'b0;
		check_val("read_valid", 64'(read_valid), 64'd0);
		end_test("dispatch in order");

		for (int i = 0; i < 40; i++) begin
			send_query($urandom_range(NREADS - 1, 0), $urandom_range(127, 0));
		end
		query_valid = 1'b0;
		drain();
		end_test("random queries");

		stall_mode = 1'b1;
		for (int i = 0; i < 40; i++) begin
			send_query($urandom_range(NREADS - 1, 0), $urandom_range(127, 0));
		end
		query_valid = 1'b0;
		drain();
		check_val("result count", 64'(results), 64'(issued));
		stall_mode = 1'b0;
		@(negedge clk);
		end_test("queries under back-pressure");

		max_inflight = 0;
		for (int i = 0; i < 12; i++) begin
			send_query($urandom_range(NREADS - 1, 0), $urandom_range(127, 0));
		end
		query_valid = 1'b0;
		drain();
		check_true("fewer than four queries were in flight at once", max_inflight == 4);
		end_test("back-to-back queries");

		$display("tests %0d, checks %0d, errors %0d", test_no, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
hdl/read_store_pkg.sv
hdl/read_loader.sv
hdl/base_ram.sv
hdl/seed_param_ram.sv
hdl/read_dispatcher.sv
hdl/base_query_pipe.sv
hdl/read_store_top.sv
test/read_store_props.sv
test/read_store_tb.sv

//--- Makefile
SIM        := verilator
TOP        := read_store_tb
FILELIST   := sources.f
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --top-module $(TOP)
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
